// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import ooo_pkg::*; (
    input  logic       exec_valid_i,
    input  exec_word_t exec_word_i,
    output cdb_wr_t    cdb_wr_o
);
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] result;

    assign op_a  = exec_word_i.src1;
    assign op_b  = exec_word_i.src2;
    // RV32I shifts only look at five bits
    assign shamt = op_b[4:0];

    always_comb begin
        case (exec_word_i.op)
            OP_ADD:  result = op_a + op_b;
            OP_SUB:  result = op_a - op_b;
            OP_SLL:  result = op_a << shamt;
            OP_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            OP_SLTU: result = {31'b0, op_a < op_b};
            OP_XOR:  result = op_a ^ op_b;
            OP_SRL:  result = op_a >> shamt;
            OP_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            OP_OR:   result = op_a | op_b;
            OP_AND:  result = op_a & op_b;
            // upper immediate already sits in operand two
            default: result = op_b;
        endcase
    end

    assign cdb_wr_o.valid = exec_valid_i;
    assign cdb_wr_o.tag   = exec_word_i.rd_tag;
    assign cdb_wr_o.data  = result;

endmodule

`default_nettype wire

// ==== cdb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb import ooo_pkg::*; #(
    parameter int NUM_RS = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  cdb_wr_t [NUM_RS-1:0]       wr_i,
    input  logic                       free_valid_i,
    input  rob_tag_t                   free_tag_i,
    output logic [ROB_DEPTH-1:0]       done_o,
    output logic [ROB_DEPTH-1:0][31:0] data_o
);

    // done bit per ROB slot, cleared when the slot retires
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_o <= '0;
        end else begin
            if (free_valid_i) done_o[free_tag_i] <= 1'b0;
            for (int i = 0; i < NUM_RS; i++) begin
                if (wr_i[i].valid) done_o[wr_i[i].tag] <= 1'b1;
            end
        end
    end

    // result store indexed by tag
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_RS; i++) begin
            if (wr_i[i].valid) data_o[wr_i[i].tag] <= wr_i[i].data;
        end
    end

    for (genvar i = 0; i < NUM_RS; i++) begin : g_wr_chk
        // a slot gets one result per allocation
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            wr_i[i].valid |-> !done_o[wr_i[i].tag]);
        for (genvar j = i + 1; j < NUM_RS; j++) begin : g_pair
            // in-flight tags are unique across stations
            assert property (@(posedge clk_i) disable iff (!rst_n_i)
                !(wr_i[i].valid && wr_i[j].valid && wr_i[i].tag == wr_i[j].tag));
        end
    end

endmodule

`default_nettype wire

// ==== instr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_queue import ooo_pkg::*; #(
    parameter int NUM_RS = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       instr_valid_i,
    input  logic [31:0]                instr_i,
    output logic                       instr_ready_o,
    input  logic                       rob_full_i,
    input  rob_tag_t                   alloc_tag_i,
    output logic                       rob_alloc_o,
    input  logic [NUM_RS-1:0]          rs_empty_i,
    output logic [NUM_RS-1:0]          rs_load_o,
    output res_word_t                  res_word_o,
    output logic [4:0]                 rs1_o,
    output logic [4:0]                 rs2_o,
    input  logic [31:0]                rf_data1_i,
    input  logic [31:0]                rf_data2_i,
    input  logic [1:0]                 rf_busy_i,
    input  rob_tag_t                   rf_tag1_i,
    input  rob_tag_t                   rf_tag2_i,
    input  logic [ROB_DEPTH-1:0]       cdb_done_i,
    input  logic [ROB_DEPTH-1:0][31:0] cdb_data_i,
    output logic                       rename_o,
    output logic [4:0]                 rename_rd_o
);
    localparam int QUEUE_DEPTH = 4;
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);

    localparam logic [6:0] OPC_OP  = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    logic [QUEUE_DEPTH-1:0][31:0] fifo_q;
    logic [PTR_W-1:0]             wr_ptr_q;
    logic [PTR_W-1:0]             rd_ptr_q;
    logic [PTR_W:0]               count_q;
    logic [31:0]                  head_word;
    ctrl_word_t                   ctrl;
    logic                         supported;
    logic                         head_valid;
    logic                         issue;
    logic                         push;
    logic                         pop;
    logic [NUM_RS-1:0]            load_sel;

    // busy source resolves from the bus once its result is done
    function automatic operand_t resolve(input logic busy, input rob_tag_t tag,
                                         input logic [31:0] rf_data,
                                         input logic [ROB_DEPTH-1:0] done,
                                         input logic [ROB_DEPTH-1:0][31:0] bus_data);
        operand_t opnd;
        opnd.tag   = tag;
        opnd.valid = !busy || done[tag];
        opnd.data  = busy ? bus_data[tag] : rf_data;
        return opnd;
    endfunction

    assign instr_ready_o = count_q != (PTR_W+1)'(QUEUE_DEPTH);
    assign head_valid    = count_q != '0;
    assign head_word     = fifo_q[rd_ptr_q];
    assign push          = instr_valid_i && instr_ready_o;
    // unsupported words fall out of the queue without issue
    assign pop           = head_valid && (issue || !supported);

    // RV32I decode of the head word
    always_comb begin
        ctrl.rd      = head_word[11:7];
        ctrl.rs1     = head_word[19:15];
        ctrl.rs2     = head_word[24:20];
        ctrl.imm     = {{20{head_word[31]}}, head_word[31:20]};
        ctrl.use_imm = 1'b1;
        supported    = 1'b1;
        case (head_word[14:12])
            3'b000:  ctrl.op = (head_word[6:0] == OPC_OP && head_word[30]) ? OP_SUB : OP_ADD;
            3'b001:  ctrl.op = OP_SLL;
            3'b010:  ctrl.op = OP_SLT;
            3'b011:  ctrl.op = OP_SLTU;
            3'b100:  ctrl.op = OP_XOR;
            3'b101:  ctrl.op = head_word[30] ? OP_SRA : OP_SRL;
            3'b110:  ctrl.op = OP_OR;
            default: ctrl.op = OP_AND;
        endcase
        case (head_word[6:0])
            OPC_OP:  ctrl.use_imm = 1'b0;
            OPC_IMM: ctrl.rs2 = 5'd0;
            OPC_LUI: begin
                ctrl.op  = OP_LUI;
                ctrl.rs1 = 5'd0;
                ctrl.rs2 = 5'd0;
                ctrl.imm = {head_word[31:12], 12'b0};
            end
            default: supported = 1'b0;
        endcase
    end

    // isolate lowest empty station
    assign load_sel = rs_empty_i & (~rs_empty_i + NUM_RS'(1));
    assign issue    = head_valid && supported && !rob_full_i && (|rs_empty_i);

    assign rs_load_o   = issue ? load_sel : '0;
    assign rob_alloc_o = issue;
    assign rename_o    = issue;
    assign rename_rd_o = ctrl.rd;
    assign rs1_o       = ctrl.rs1;
    assign rs2_o       = ctrl.rs2;

    always_comb begin
        res_word_o.op     = ctrl.op;
        res_word_o.rd_tag = alloc_tag_i;
        res_word_o.src1   = resolve(rf_busy_i[0], rf_tag1_i, rf_data1_i, cdb_done_i, cdb_data_i);
        res_word_o.src2   = resolve(rf_busy_i[1], rf_tag2_i, rf_data2_i, cdb_done_i, cdb_data_i);
        // immediate forms carry the constant as a ready operand
        if (ctrl.use_imm) begin
            res_word_o.src2.tag   = '0;
            res_word_o.src2.data  = ctrl.imm;
            res_word_o.src2.valid = 1'b1;
        end
    end

    // queue pointers
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) fifo_q[wr_ptr_q] <= instr_i;
    end

    // occupancy never passes the queue depth
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q <= (PTR_W+1)'(QUEUE_DEPTH));

endmodule

`default_nettype wire

// ==== ooo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo import ooo_pkg::*; #(
    parameter int NUM_RS = 4
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    output logic        instr_ready_o,
    output logic        commit_valid_o,
    output commit_t     commit_o
);
    // issue control
    logic                       rob_full;
    logic                       rob_alloc;
    rob_tag_t                   alloc_tag;
    logic                       rename;
    logic [4:0]                 rename_rd;
    logic [NUM_RS-1:0]          rs_empty;
    logic [NUM_RS-1:0]          rs_load;
    res_word_t                  res_word;
    // register file read side
    logic [4:0]                 rs1;
    logic [4:0]                 rs2;
    logic [31:0]                rf_data1;
    logic [31:0]                rf_data2;
    logic [1:0]                 rf_busy;
    rob_tag_t                   rf_tag1;
    rob_tag_t                   rf_tag2;
    // execute and result bus
    logic [NUM_RS-1:0]          exec_valid;
    exec_word_t [NUM_RS-1:0]    exec_word;
    cdb_wr_t [NUM_RS-1:0]       cdb_wr;
    logic [ROB_DEPTH-1:0]       cdb_done;
    logic [ROB_DEPTH-1:0][31:0] cdb_data;
    rob_tag_t                   commit_tag;

    instr_queue #(.NUM_RS(NUM_RS)) iq (
        .clk_i, .rst_n_i, .instr_valid_i, .instr_i, .instr_ready_o,
        .rob_full_i  (rob_full),
        .alloc_tag_i (alloc_tag),
        .rob_alloc_o (rob_alloc),
        .rs_empty_i  (rs_empty),
        .rs_load_o   (rs_load),
        .res_word_o  (res_word),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rf_data1_i  (rf_data1),
        .rf_data2_i  (rf_data2),
        .rf_busy_i   (rf_busy),
        .rf_tag1_i   (rf_tag1),
        .rf_tag2_i   (rf_tag2),
        .cdb_done_i  (cdb_done),
        .cdb_data_i  (cdb_data),
        .rename_o    (rename),
        .rename_rd_o (rename_rd)
    );

    // renaming uses the same tag the ROB allocates
    regfile rf (
        .clk_i, .rst_n_i,
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .data1_o        (rf_data1),
        .data2_o        (rf_data2),
        .busy_o         (rf_busy),
        .tag1_o         (rf_tag1),
        .tag2_o         (rf_tag2),
        .rename_i       (rename),
        .rename_rd_i    (rename_rd),
        .rename_tag_i   (alloc_tag),
        .commit_valid_i (commit_valid_o),
        .commit_i       (commit_o),
        .commit_tag_i   (commit_tag)
    );

    // one station per ALU, all share the issue word
    for (genvar i = 0; i < NUM_RS; i++) begin : g_exec
        reservation_station rs (
            .clk_i, .rst_n_i,
            .load_i       (rs_load[i]),
            .res_word_i   (res_word),
            .cdb_done_i   (cdb_done),
            .cdb_data_i   (cdb_data),
            .empty_o      (rs_empty[i]),
            .exec_valid_o (exec_valid[i]),
            .exec_word_o  (exec_word[i])
        );

        alu alu_i (
            .exec_valid_i (exec_valid[i]),
            .exec_word_i  (exec_word[i]),
            .cdb_wr_o     (cdb_wr[i])
        );
    end

    // retiring slot frees its done bit
    cdb #(.NUM_RS(NUM_RS)) bus (
        .clk_i, .rst_n_i,
        .wr_i         (cdb_wr),
        .free_valid_i (commit_valid_o),
        .free_tag_i   (commit_tag),
        .done_o       (cdb_done),
        .data_o       (cdb_data)
    );

    rob rob_i (
        .clk_i, .rst_n_i,
        .alloc_i        (rob_alloc),
        .alloc_rd_i     (rename_rd),
        .alloc_tag_o    (alloc_tag),
        .full_o         (rob_full),
        .done_i         (cdb_done),
        .data_i         (cdb_data),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .commit_tag_o   (commit_tag)
    );

endmodule

`default_nettype wire

// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // reorder buffer size, tag width follows from it
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = $clog2(ROB_DEPTH);

    typedef logic [TAG_W-1:0] rob_tag_t;

    // integer operations handled by the ALUs
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_LUI
    } alu_op_t;

    // decoded instruction at the queue head
    typedef struct packed {
        alu_op_t     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        use_imm;
    } ctrl_word_t;

    // one source operand, either a value or a pending tag
    typedef struct packed {
        rob_tag_t    tag;
        logic [31:0] data;
        logic        valid;
    } operand_t;

    // station payload written at issue
    typedef struct packed {
        alu_op_t  op;
        operand_t src1;
        operand_t src2;
        rob_tag_t rd_tag;
    } res_word_t;

    // ready-to-run word from a station to its ALU
    typedef struct packed {
        alu_op_t     op;
        logic [31:0] src1;
        logic [31:0] src2;
        rob_tag_t    rd_tag;
    } exec_word_t;

    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] data;
    } cdb_wr_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } commit_t;

endpackage

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import ooo_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    output logic [31:0] data1_o,
    output logic [31:0] data2_o,
    output logic [1:0]  busy_o,
    output rob_tag_t    tag1_o,
    output rob_tag_t    tag2_o,
    input  logic        rename_i,
    input  logic [4:0]  rename_rd_i,
    input  rob_tag_t    rename_tag_i,
    input  logic        commit_valid_i,
    input  commit_t     commit_i,
    input  rob_tag_t    commit_tag_i
);
    logic [31:0][31:0] regs_q;
    logic [31:0]       busy_q;
    rob_tag_t [31:0]   tag_q;

    // x0 is never renamed or written so it reads zero and idle
    assign data1_o = regs_q[rs1_i];
    assign data2_o = regs_q[rs2_i];
    assign busy_o  = {busy_q[rs2_i], busy_q[rs1_i]};
    assign tag1_o  = tag_q[rs1_i];
    assign tag2_o  = tag_q[rs2_i];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            regs_q <= '0;
            busy_q <= '0;
            tag_q  <= '0;
        end else begin
            if (commit_valid_i && commit_i.rd != 5'd0) begin
                regs_q[commit_i.rd] <= commit_i.data;
                // younger producer still owns the register
                if (tag_q[commit_i.rd] == commit_tag_i) begin
                    busy_q[commit_i.rd] <= 1'b0;
                end
            end
            // rename comes last and wins on a shared register
            if (rename_i && rename_rd_i != 5'd0) begin
                busy_q[rename_rd_i] <= 1'b1;
                tag_q[rename_rd_i]  <= rename_tag_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       load_i,
    input  res_word_t                  res_word_i,
    input  logic [ROB_DEPTH-1:0]       cdb_done_i,
    input  logic [ROB_DEPTH-1:0][31:0] cdb_data_i,
    output logic                       empty_o,
    output logic                       exec_valid_o,
    output exec_word_t                 exec_word_o
);
    logic      busy_q;
    res_word_t word_q;

    // pending operand picks up its value once the tag is done
    function automatic operand_t snoop(input operand_t opnd,
                                       input logic [ROB_DEPTH-1:0] done,
                                       input logic [ROB_DEPTH-1:0][31:0] bus_data);
        operand_t nxt;
        nxt = opnd;
        if (!opnd.valid && done[opnd.tag]) begin
            nxt.data  = bus_data[opnd.tag];
            nxt.valid = 1'b1;
        end
        return nxt;
    endfunction

    assign empty_o      = !busy_q;
    // fires once both sources hold values
    assign exec_valid_o = busy_q && word_q.src1.valid && word_q.src2.valid;

    assign exec_word_o.op     = word_q.op;
    assign exec_word_o.src1   = word_q.src1.data;
    assign exec_word_o.src2   = word_q.src2.data;
    assign exec_word_o.rd_tag = word_q.rd_tag;

    // occupancy, freed on the firing edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (load_i) begin
            busy_q <= 1'b1;
        end else if (exec_valid_o) begin
            busy_q <= 1'b0;
        end
    end

    // payload plus wake-up from the bus
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            word_q <= res_word_i;
        end else begin
            word_q.src1 <= snoop(word_q.src1, cdb_done_i, cdb_data_i);
            word_q.src2 <= snoop(word_q.src2, cdb_done_i, cdb_data_i);
        end
    end

    // issue only ever targets an empty station
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_i |-> !busy_q);

endmodule

`default_nettype wire

// ==== rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob import ooo_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       alloc_i,
    input  logic [4:0]                 alloc_rd_i,
    output rob_tag_t                   alloc_tag_o,
    output logic                       full_o,
    input  logic [ROB_DEPTH-1:0]       done_i,
    input  logic [ROB_DEPTH-1:0][31:0] data_i,
    output logic                       commit_valid_o,
    output commit_t                    commit_o,
    output rob_tag_t                   commit_tag_o
);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    rob_tag_t                  head_q;
    rob_tag_t                  tail_q;
    logic [CNT_W-1:0]          count_q;
    logic [ROB_DEPTH-1:0][4:0] rd_q;
    logic                      retire;

    // tail slot is the tag handed out at issue
    assign alloc_tag_o = tail_q;
    assign full_o      = count_q == CNT_W'(ROB_DEPTH);
    // in order, only the head may leave
    assign retire      = count_q != '0 && done_i[head_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire;
            if (alloc_i) tail_q <= tail_q + 1'b1;
            if (retire) head_q <= head_q + 1'b1;
            count_q <= count_q + CNT_W'(alloc_i) - CNT_W'(retire);
        end
    end

    // destination per entry and the registered commit word
    always_ff @(posedge clk_i) begin
        if (alloc_i) rd_q[tail_q] <= alloc_rd_i;
        if (retire) begin
            commit_o.rd   <= rd_q[head_q];
            // x0 always retires as zero
            commit_o.data <= (rd_q[head_q] == 5'd0) ? 32'd0 : data_i[head_q];
            commit_tag_o  <= head_q;
        end
    end

    // queue holds its word while the buffer is full
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_i |-> !full_o);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the ooo testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo -f verilog.f -o sim_ooo
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_ooo > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// ==== tb_ooo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo import ooo_pkg::*; ();

    localparam int N_RANDOM = 160;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F_ADD  = 3'd0;
    localparam logic [2:0] F_SLL  = 3'd1;
    localparam logic [2:0] F_SLT  = 3'd2;
    localparam logic [2:0] F_SLTU = 3'd3;
    localparam logic [2:0] F_XOR  = 3'd4;
    localparam logic [2:0] F_SR   = 3'd5;
    localparam logic [2:0] F_OR   = 3'd6;
    localparam logic [2:0] F_AND  = 3'd7;

    // table row holds the word, an optional idle cycle before it and the expected retirement
    typedef struct packed {
        logic [31:0] instr;
        logic        idle;
        commit_t     exp;
    } step_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        commit_valid;
    commit_t     commit;

    step_t       steps[$];
    commit_t     exp_q[$];
    commit_t     exp_c;
    logic [31:0] gold_regs [32];
    logic [31:0] seed = 32'd94834;
    logic        saw_stall = 1'b0;
    int          errors = 0;
    int          n_commits = 0;
    int          cycles = 0;
    int          cycle_limit = 100;

    ooo #(.NUM_RS(4)) ooo_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .instr_ready_o  (instr_ready),
        .commit_valid_o (commit_valid),
        .commit_o       (commit)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RV32I encoders
    function automatic logic [31:0] r_type(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3,
                                           input logic alt);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // architectural model runs one word at a time in program order
    task automatic run_model(input logic [31:0] w, output commit_t c);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  sh;
        logic        is_op;
        a     = gold_regs[w[19:15]];
        is_op = w[6:0] == 7'b0110011;
        b     = is_op ? gold_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh    = b[4:0];
        case (w[14:12])
            F_ADD:   res = (is_op && w[30]) ? a - b : a + b;
            F_SLL:   res = a << sh;
            // differing signs decide alone and equal signs compare as magnitudes
            F_SLT:   res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            F_SLTU:  res = {31'b0, a < b};
            F_XOR:   res = a ^ b;
            F_SR:    res = w[30] ? (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0)
                                 : a >> sh;
            F_OR:    res = a | b;
            default: res = a & b;
        endcase
        if (w[6:0] == 7'b0110111) res = {w[31:12], 12'h000};
        c.rd   = w[11:7];
        c.data = (c.rd == 5'd0) ? 32'd0 : res;
        if (c.rd != 5'd0) gold_regs[c.rd] = res;
    endtask

    task automatic add_step(input logic [31:0] w, input logic idle);
        step_t s;
        s.instr = w;
        s.idle  = idle;
        run_model(w, s.exp);
        steps.push_back(s);
    endtask

    // supported opcodes only with registers x0..x15 for dense dependencies
    task automatic random_step();
        logic [31:0] r;
        logic [31:0] w;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        seed = lcg_next(seed);
        r    = seed;
        seed = lcg_next(seed);
        imm  = seed[31:20];
        f3   = r[15:13];
        alt  = r[12] && (f3 == F_ADD || f3 == F_SR);
        if (r[31:30] != 2'd3) begin
            w = r_type({1'b0, r[27:24]}, {1'b0, r[23:20]}, {1'b0, r[19:16]}, f3, alt);
        end else if (!r[29]) begin
            if (f3 == F_SLL) imm = {7'b0, imm[4:0]};
            if (f3 == F_SR) imm = {1'b0, r[12], 5'b0, imm[4:0]};
            w = i_type({1'b0, r[27:24]}, {1'b0, r[23:20]}, f3, imm);
        end else begin
            w = u_type({1'b0, r[27:24]}, {imm, seed[19:12]});
        end
        add_step(w, seed[10:9] == 2'b00);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s, got %08h expected %08h", $time, msg, actual, expected);
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < 32; i++) gold_regs[i] = 32'd0;
        // operand setup with x5 built by a dependent pair
        add_step(u_type(5'd1, 20'h80000), 1'b0);
        add_step(i_type(5'd2, 5'd0, F_ADD, 12'hfff), 1'b0);
        add_step(i_type(5'd3, 5'd0, F_ADD, 12'h005), 1'b0);
        add_step(i_type(5'd4, 5'd0, F_ADD, 12'h7ff), 1'b0);
        add_step(u_type(5'd5, 20'h80000), 1'b0);
        add_step(i_type(5'd5, 5'd5, F_ADD, 12'hfff), 1'b0);
        add_step(i_type(5'd11, 5'd0, F_ADD, 12'd31), 1'b0);
        // signed overflow both ways
        add_step(r_type(5'd6, 5'd5, 5'd3, F_ADD, 1'b0), 1'b0);
        add_step(r_type(5'd7, 5'd1, 5'd3, F_ADD, 1'b1), 1'b0);
        // shifts by 31 in immediate and register form
        add_step(i_type(5'd8, 5'd3, F_SLL, 12'd31), 1'b0);
        add_step(i_type(5'd9, 5'd2, F_SR, 12'd31), 1'b0);
        add_step(i_type(5'd10, 5'd1, F_SR, 12'h41f), 1'b0);
        add_step(r_type(5'd12, 5'd1, 5'd11, F_SR, 1'b1), 1'b0);
        add_step(r_type(5'd13, 5'd1, 5'd11, F_SR, 1'b0), 1'b0);
        add_step(r_type(5'd14, 5'd2, 5'd11, F_SLL, 1'b0), 1'b0);
        // -1 against 5 in signed and unsigned compare
        add_step(r_type(5'd15, 5'd2, 5'd3, F_SLT, 1'b0), 1'b0);
        add_step(r_type(5'd16, 5'd2, 5'd3, F_SLTU, 1'b0), 1'b0);
        add_step(i_type(5'd17, 5'd1, F_SLT, 12'h000), 1'b0);
        add_step(i_type(5'd18, 5'd3, F_SLTU, 12'hfff), 1'b0);
        add_step(r_type(5'd19, 5'd2, 5'd3, F_XOR, 1'b0), 1'b0);
        add_step(r_type(5'd20, 5'd1, 5'd3, F_OR, 1'b0), 1'b0);
        add_step(r_type(5'd21, 5'd2, 5'd4, F_AND, 1'b0), 1'b0);
        add_step(i_type(5'd22, 5'd3, F_XOR, 12'hfff), 1'b0);
        add_step(i_type(5'd23, 5'd1, F_OR, 12'h555), 1'b0);
        add_step(i_type(5'd24, 5'd2, F_AND, 12'h0f0), 1'b0);
        // writes to x0 must not stick
        add_step(i_type(5'd0, 5'd3, F_ADD, 12'h007), 1'b0);
        add_step(r_type(5'd25, 5'd0, 5'd3, F_ADD, 1'b0), 1'b0);
        add_step(r_type(5'd0, 5'd25, 5'd25, F_ADD, 1'b0), 1'b0);
        add_step(r_type(5'd26, 5'd0, 5'd0, F_OR, 1'b0), 1'b0);
        // long chain on x27 backs up stations, ROB and queue
        for (int k = 0; k < 12; k++) begin
            add_step(r_type(5'd27, 5'd27, k[0] ? 5'd2 : 5'd3, k[0] ? F_XOR : F_ADD, 1'b0),
                     1'b0);
        end
        // independents can overtake the short chain on x28
        for (int k = 0; k < 3; k++) add_step(r_type(5'd28, 5'd28, 5'd27, F_ADD, 1'b0), 1'b0);
        add_step(r_type(5'd29, 5'd4, 5'd3, F_ADD, 1'b1), 1'b0);
        add_step(r_type(5'd30, 5'd1, 5'd2, F_XOR, 1'b0), 1'b0);
        add_step(r_type(5'd31, 5'd3, 5'd4, F_SLTU, 1'b0), 1'b0);
        add_step(i_type(5'd29, 5'd29, F_SLL, 12'd4), 1'b0);
        for (int k = 0; k < N_RANDOM; k++) random_step();
        cycle_limit = 20 * steps.size() + 100;
    endtask

    // retirements checked mid-cycle against the expected order
    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected commit at %0t with no instruction outstanding", $time);
            end else begin
                exp_c = exp_q.pop_front();
                check({27'b0, commit.rd}, {27'b0, exp_c.rd},
                      $sformatf("commit %0d rd", n_commits));
                check(commit.data, exp_c.data, $sformatf("commit %0d data", n_commits));
                n_commits++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d commits still missing", cycles,
                     exp_q.size());
            $display("errors: %0d, commits seen: %0d", errors, n_commits);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        build_table();
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        // quiet core before the first word
        repeat (3) begin
            @(negedge clk);
            check({31'b0, commit_valid}, 32'd0, "commit_valid_o after reset");
            check({31'b0, instr_ready}, 32'd1, "instr_ready_o after reset");
        end
        @(posedge clk);
        #0.5;
        for (int i = 0; i < steps.size(); i++) begin
            if (steps[i].idle) begin
                instr_valid = 1'b0;
                @(posedge clk);
                #0.5;
            end
            instr_valid = 1'b1;
            instr       = steps[i].instr;
            // ready is a registered level and stays stable once driven
            while (!instr_ready) begin
                saw_stall = 1'b1;
                @(posedge clk);
                #0.5;
            end
            exp_q.push_back(steps[i].exp);
            @(posedge clk);
            #0.5;
        end
        instr_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        // any extra retirement shows up here
        repeat (4) @(posedge clk);
        if (!saw_stall) begin
            errors++;
            $display("instr_ready_o never dropped during back-to-back input");
        end
        $display("errors: %0d, commits seen: %0d of %0d", errors, n_commits, steps.size());
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
ooo_pkg.sv
alu.sv
cdb.sv
regfile.sv
reservation_station.sv
rob.sv
instr_queue.sv
ooo.sv
tb_ooo.sv
